//--- rtl/midi_macros.svh
`ifndef MIDI_MACROS_SVH
`define MIDI_MACROS_SVH

// ------------------------------------------------------------
// Channel voice status nibbles (upper half of a status byte)
// ------------------------------------------------------------
`define MIDI_STATUS_NOTE_OFF 4'h8
`define MIDI_STATUS_NOTE_ON 4'h9
`define MIDI_STATUS_CC 4'hB
`define MIDI_STATUS_PROG 4'hC

// Controller numbers
`define MIDI_CC_ALL_NOTES_OFF 7'd123

// Payload width of a data byte
`define MIDI_DATA_W 7

// 50 MHz clock at 31250 baud
`define MIDI_CLKS_PER_BIT 1600

`endif

//--- rtl/midi_pkg.sv
package midi_pkg;

    // Serial receiver states
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    // Message parser states
    typedef enum logic [3:0] {
        st_recv,
        st_dispatch,
        st_recv_num,
        st_recv_vel,
        st_handle_note,
        st_recv_prog,
        st_handle_prog,
        st_recv_cc_num,
        st_recv_cc_val,
        st_handle_cc
    } parse_state_t;

    // Decoded kind of a channel status byte
    typedef enum logic [2:0] {
        kind_note_off,
        kind_note_on,
        kind_cc,
        kind_prog,
        kind_other
    } msg_kind_t;

endpackage

//--- rtl/midi_uart_rx.sv
`timescale 1ns/1ps
`include "midi_macros.svh"

module midi_uart_rx
    import midi_pkg::*;
#(
    parameter int CLKS_PER_BIT = `MIDI_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] data,
    output logic       dv
);

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'((CLKS_PER_BIT - 1) / 2);

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       rx_shift;
    logic             bit_end;

    // ------------------------------------------------------------
    // Line synchronizer, idles high
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign bit_end = (cnt == LAST_CNT);

    // ------------------------------------------------------------
    // Bit timing FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            dv      <= 1'b0;
        end else begin
            dv <= 1'b0;
            case (state)
                rx_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // Start bit must still be low at mid-bit
                    if (cnt == HALF_CNT) begin
                        cnt   <= '0;
                        state <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= rx_idle;
                        dv    <= rx_sync;   // framing error drops the byte
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_end) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        if (state == rx_stop && bit_end && rx_sync) begin
            data <= rx_shift;
        end
    end

endmodule

//--- rtl/midi_parser.sv
`timescale 1ns/1ps
`include "midi_macros.svh"

module midi_parser
    import midi_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] channel,
    input  logic [7:0] data,
    input  logic       dv,
    output logic [6:0] note_num,
    output logic [6:0] note_vel,
    output logic [6:0] program_num,
    output logic [6:0] cc_num,
    output logic [6:0] cc_val,
    output logic       note_on,
    output logic       note_off,
    output logic       cc_valid
);

    parse_state_t             state;
    parse_state_t             state_next;
    msg_kind_t                status_kind;
    logic [7:0]               status_buf;
    logic [`MIDI_DATA_W-1:0]  num_buf;
    logic [`MIDI_DATA_W-1:0]  vel_buf;
    logic [`MIDI_DATA_W-1:0]  prog_buf;
    logic [`MIDI_DATA_W-1:0]  cc_num_buf;
    logic [`MIDI_DATA_W-1:0]  cc_val_buf;
    logic                     status_byte;
    logic                     data_byte;
    logic                     receiving;
    logic                     channel_hit;
    logic                     note_on_in;
    logic                     note_off_in;

    function automatic msg_kind_t decode_kind(input logic [3:0] nibble);
        case (nibble)
            `MIDI_STATUS_NOTE_OFF: return kind_note_off;
            `MIDI_STATUS_NOTE_ON:  return kind_note_on;
            `MIDI_STATUS_CC:       return kind_cc;
            `MIDI_STATUS_PROG:     return kind_prog;
            default:               return kind_other;
        endcase
    endfunction

    assign status_byte = dv && data[7];
    assign data_byte   = dv && !data[7];
    assign status_kind = decode_kind(status_buf[7:4]);
    assign channel_hit = (status_buf[3:0] == channel);
    assign receiving   = state inside {st_recv, st_recv_num, st_recv_vel, st_recv_prog,
                                       st_recv_cc_num, st_recv_cc_val};

    // ------------------------------------------------------------
    // Message FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_recv;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        // A status byte always restarts the message
        if (receiving && status_byte) begin
            state_next = st_dispatch;
        end else begin
            case (state)
                st_dispatch: begin
                    state_next = st_recv;
                    if (channel_hit) begin
                        case (status_kind)
                            kind_note_off, kind_note_on: state_next = st_recv_num;
                            kind_prog:                   state_next = st_recv_prog;
                            kind_cc:                     state_next = st_recv_cc_num;
                            default:                     state_next = st_recv;
                        endcase
                    end
                end
                st_recv_num:    if (data_byte) state_next = st_recv_vel;
                st_recv_vel:    if (data_byte) state_next = st_handle_note;
                st_recv_prog:   if (data_byte) state_next = st_handle_prog;
                st_recv_cc_num: if (data_byte) state_next = st_recv_cc_val;
                st_recv_cc_val: if (data_byte) state_next = st_handle_cc;
                st_handle_note, st_handle_prog, st_handle_cc: state_next = st_recv;
                default:        state_next = state;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Status and data buffers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            status_buf <= '0;
            num_buf    <= '0;
            vel_buf    <= '0;
            prog_buf   <= '0;
            cc_num_buf <= '0;
            cc_val_buf <= '0;
        end else begin
            if (receiving && status_byte) status_buf <= data;
            if (state == st_recv_num && data_byte) num_buf <= data[6:0];
            if (state == st_recv_vel && data_byte) vel_buf <= data[6:0];
            if (state == st_recv_prog && data_byte) prog_buf <= data[6:0];
            if (state == st_recv_cc_num && data_byte) cc_num_buf <= data[6:0];
            if (state == st_recv_cc_val && data_byte) cc_val_buf <= data[6:0];
        end
    end

    // Note-on with zero velocity counts as note-off
    assign note_off_in = (state == st_handle_note) &&
                         (status_kind == kind_note_off || vel_buf == '0);
    assign note_on_in  = (state == st_handle_note) &&
                         (status_kind == kind_note_on) && (vel_buf != '0);

    // ------------------------------------------------------------
    // Registered event outputs
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            note_on     <= 1'b0;
            note_off    <= 1'b0;
            cc_valid    <= 1'b0;
            note_num    <= '0;
            note_vel    <= '0;
            program_num <= '0;
            cc_num      <= '0;
            cc_val      <= '0;
        end else begin
            note_on  <= note_on_in;
            note_off <= note_off_in;
            cc_valid <= (state == st_handle_cc);
            if (state == st_handle_note) begin
                note_num <= num_buf;
                note_vel <= vel_buf;
            end
            if (state == st_handle_prog) program_num <= prog_buf;
            if (state == st_handle_cc) begin
                cc_num <= cc_num_buf;
                cc_val <= cc_val_buf;
            end
        end
    end

endmodule

//--- rtl/midi_note_tracker.sv
`timescale 1ns/1ps
`include "midi_macros.svh"

module midi_note_tracker
    import midi_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] note_num,
    input  logic       note_on,
    input  logic       note_off,
    input  logic [6:0] cc_num,
    input  logic       cc_valid,
    output logic       gate,
    output logic [7:0] held_count
);

    localparam int KEYS = 1 << `MIDI_DATA_W;

    logic [KEYS-1:0] held;
    logic [7:0]      count_next;
    logic            key_held;
    msg_kind_t       event_kind;

    assign key_held = held[note_num];

    // ------------------------------------------------------------
    // Classify the incoming event
    // ------------------------------------------------------------
    always_comb begin
        if (note_on) begin
            event_kind = kind_note_on;
        end else if (note_off) begin
            event_kind = kind_note_off;
        end else if (cc_valid && cc_num == `MIDI_CC_ALL_NOTES_OFF) begin
            event_kind = kind_cc;
        end else begin
            event_kind = kind_other;
        end
    end

    // Count moves only when the key actually changes state
    always_comb begin
        count_next = held_count;
        case (event_kind)
            kind_note_on: begin
                if (!key_held) count_next = held_count + 8'd1;
            end
            kind_note_off: begin
                if (key_held) count_next = held_count - 8'd1;
            end
            kind_cc: count_next = 8'd0;
            default: count_next = held_count;
        endcase
    end

    // ------------------------------------------------------------
    // Held set, count and gate
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            held       <= '0;
            held_count <= 8'd0;
            gate       <= 1'b0;
        end else begin
            case (event_kind)
                kind_note_on:  held[note_num] <= 1'b1;
                kind_note_off: held[note_num] <= 1'b0;
                kind_cc:       held <= '0;
                default:       held <= held;
            endcase
            held_count <= count_next;
            gate       <= (count_next != 8'd0);
        end
    end

endmodule

//--- rtl/midi_top.sv
`timescale 1ns/1ps
`include "midi_macros.svh"

module midi_top #(
    parameter int CLKS_PER_BIT = `MIDI_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    input  logic [3:0] channel,
    output logic [6:0] note_num,
    output logic [6:0] note_vel,
    output logic [6:0] program_num,
    output logic [6:0] cc_num,
    output logic [6:0] cc_val,
    output logic       note_on,
    output logic       note_off,
    output logic       cc_valid,
    output logic       gate,
    output logic [7:0] held_count
);

    logic [7:0] rx_data;
    logic       rx_dv;

    midi_uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .data  (rx_data),
        .dv    (rx_dv)
    );

    midi_parser u_parser (
        .clk         (clk),
        .reset       (reset),
        .channel     (channel),
        .data        (rx_data),
        .dv          (rx_dv),
        .note_num    (note_num),
        .note_vel    (note_vel),
        .program_num (program_num),
        .cc_num      (cc_num),
        .cc_val      (cc_val),
        .note_on     (note_on),
        .note_off    (note_off),
        .cc_valid    (cc_valid)
    );

    midi_note_tracker u_tracker (
        .clk        (clk),
        .reset      (reset),
        .note_num   (note_num),
        .note_on    (note_on),
        .note_off   (note_off),
        .cc_num     (cc_num),
        .cc_valid   (cc_valid),
        .gate       (gate),
        .held_count (held_count)
    );

endmodule

//--- testbench/tb_midi_top.sv
`timescale 1ns/1ps

module tb_midi_top;

    localparam int CLKS_PER_BIT = 16;
    localparam int WAIT_LIMIT = 40 * CLKS_PER_BIT;
    localparam logic [3:0] CHAN = 4'd5;
    localparam logic [3:0] OTHER = 4'd9;

    logic       clk;
    logic       reset;
    logic       rx;
    logic [3:0] channel;
    logic [6:0] note_num;
    logic [6:0] note_vel;
    logic [6:0] program_num;
    logic [6:0] cc_num;
    logic [6:0] cc_val;
    logic       note_on;
    logic       note_off;
    logic       cc_valid;
    logic       gate;
    logic [7:0] held_count;

    integer       seed;
    int           errors;
    int           checks;
    int           on_count;
    int           off_count;
    int           cc_count;
    logic [6:0]   seen_num;
    logic [6:0]   seen_vel;
    logic [6:0]   seen_cc_num;
    logic [6:0]   seen_cc_val;
    logic [127:0] held_model;
    int           exp_count;
    logic [6:0]   exp_program;

    midi_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .channel     (channel),
        .note_num    (note_num),
        .note_vel    (note_vel),
        .program_num (program_num),
        .cc_num      (cc_num),
        .cc_val      (cc_val),
        .note_on     (note_on),
        .note_off    (note_off),
        .cc_valid    (cc_valid),
        .gate        (gate),
        .held_count  (held_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Event monitor, samples mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(note_on && note_off)) else begin
                errors++;
                $display("note_on and note_off were high in the same cycle");
            end
            if (note_on || note_off) begin
                seen_num = note_num;
                seen_vel = note_vel;
            end
            if (note_on) on_count++;
            if (note_off) off_count++;
            if (cc_valid) begin
                cc_count++;
                seen_cc_num = cc_num;
                seen_cc_val = cc_val;
            end
        end
    end

    task automatic check_value(input string test, input string what, input int expected,
                               input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
    endtask

    task automatic send_msg(input logic [7:0] status, input logic [6:0] d0, input logic [6:0] d1);
        send_byte(status);
        send_byte({1'b0, d0});
        send_byte({1'b0, d1});
    endtask

    function automatic int event_count(input int kind);
        case (kind)
            0: return on_count;
            1: return off_count;
            default: return cc_count;
        endcase
    endfunction

    // kind 0 is note_on, 1 is note_off, 2 is cc_valid
    task automatic wait_for_event(input string test, input int kind, input int target);
        int cycles;
        cycles = 0;
        while (event_count(kind) < target && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (event_count(kind) >= target) else begin
            errors++;
            $display("%s: timed out waiting for an event pulse", test);
        end
        @(negedge clk);
    endtask

    task automatic wait_for_program(input string test, input logic [6:0] value);
        int cycles;
        cycles = 0;
        while (program_num != value && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (program_num == value) else begin
            errors++;
            $display("%s: timed out waiting for the program output to change", test);
        end
    endtask

    // Long enough for any stray event to show up
    task automatic settle();
        repeat (3 * CLKS_PER_BIT) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic mark_note(input logic [6:0] key, input logic on);
        if (on && !held_model[key]) exp_count++;
        if (!on && held_model[key]) exp_count--;
        held_model[key] = on;
    endtask

    task automatic check_tracker(input string test);
        check_value(test, "held_count", exp_count, held_count);
        check_value(test, "gate", exp_count != 0, gate);
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic test_note_on_off();
        logic [6:0] key;
        logic [6:0] vel;
        int         base_on;
        int         base_off;
        key = $random(seed);
        vel = $random(seed);
        if (vel == 7'd0) vel = 7'd64;
        base_on = on_count;
        base_off = off_count;
        send_msg({4'h9, CHAN}, key, vel);
        wait_for_event("test_note_on_off", 0, base_on + 1);
        mark_note(key, 1'b1);
        check_value("test_note_on_off", "note_on pulses", base_on + 1, on_count);
        check_value("test_note_on_off", "note_num", key, seen_num);
        check_value("test_note_on_off", "note_vel", vel, seen_vel);
        check_tracker("test_note_on_off");
        send_msg({4'h8, CHAN}, key, 7'd40);
        wait_for_event("test_note_on_off", 1, base_off + 1);
        mark_note(key, 1'b0);
        check_value("test_note_on_off", "note_off pulses", base_off + 1, off_count);
        check_value("test_note_on_off", "note_off key", key, seen_num);
        check_tracker("test_note_on_off");
    endtask

    task automatic test_velocity_zero();
        logic [6:0] key;
        int         base_on;
        int         base_off;
        key = $random(seed);
        base_on = on_count;
        base_off = off_count;
        send_msg({4'h9, CHAN}, key, 7'd0);
        wait_for_event("test_velocity_zero", 1, base_off + 1);
        settle();
        mark_note(key, 1'b0);
        check_value("test_velocity_zero", "note_off pulses", base_off + 1, off_count);
        check_value("test_velocity_zero", "note_on pulses", base_on, on_count);
        check_tracker("test_velocity_zero");
    endtask

    task automatic test_channel_filter();
        logic [6:0] key;
        int         base_on;
        int         base_off;
        int         base_cc;
        key = $random(seed);
        // Hold a key so a foreign all-notes-off has something to clear
        base_on = on_count;
        send_msg({4'h9, CHAN}, key, 7'd100);
        wait_for_event("test_channel_filter", 0, base_on + 1);
        mark_note(key, 1'b1);
        base_on = on_count;
        base_off = off_count;
        base_cc = cc_count;
        send_msg({4'h9, OTHER}, key ^ 7'd1, 7'd90);
        send_byte({4'hC, OTHER});
        send_byte({1'b0, exp_program ^ 7'd3});
        send_msg({4'hB, OTHER}, 7'd123, 7'd0);
        settle();
        check_value("test_channel_filter", "note_on pulses", base_on, on_count);
        check_value("test_channel_filter", "note_off pulses", base_off, off_count);
        check_value("test_channel_filter", "cc_valid pulses", base_cc, cc_count);
        check_value("test_channel_filter", "program", exp_program, program_num);
        check_tracker("test_channel_filter");
        send_msg({4'h8, CHAN}, key, 7'd0);
        wait_for_event("test_channel_filter", 1, base_off + 1);
        mark_note(key, 1'b0);
        check_tracker("test_channel_filter");
    endtask

    task automatic test_program_cc();
        logic [6:0] prog;
        logic [6:0] num;
        logic [6:0] val;
        int         base_cc;
        prog = $random(seed);
        if (prog == exp_program) prog = prog ^ 7'd1;
        send_byte({4'hC, CHAN});
        send_byte({1'b0, prog});
        wait_for_program("test_program_cc", prog);
        exp_program = prog;
        check_value("test_program_cc", "program", exp_program, program_num);
        num = $random(seed);
        if (num == 7'd123) num = 7'd122;
        val = $random(seed);
        base_cc = cc_count;
        send_msg({4'hB, CHAN}, num, val);
        wait_for_event("test_program_cc", 2, base_cc + 1);
        check_value("test_program_cc", "cc_valid pulses", base_cc + 1, cc_count);
        check_value("test_program_cc", "cc_num", num, seen_cc_num);
        check_value("test_program_cc", "cc_val", val, seen_cc_val);
        check_tracker("test_program_cc");
    endtask

    task automatic test_held_set();
        logic [6:0] keys [4];
        logic [6:0] k0;
        int         base_on;
        int         base_cc;
        k0 = $random(seed);
        keys = '{k0, k0 + 7'd1, k0, k0 + 7'd2};
        for (int i = 0; i < 4; i++) begin
            base_on = on_count;
            send_msg({4'h9, CHAN}, keys[i], 7'd80);
            wait_for_event("test_held_set", 0, base_on + 1);
            mark_note(keys[i], 1'b1);
        end
        check_value("test_held_set", "held_count", 3, held_count);
        check_tracker("test_held_set");
        base_cc = cc_count;
        send_msg({4'hB, CHAN}, 7'd123, 7'd0);
        wait_for_event("test_held_set", 2, base_cc + 1);
        held_model = '0;
        exp_count = 0;
        check_tracker("test_held_set");
    endtask

    task automatic test_status_abort();
        logic [6:0] prog;
        int         base_on;
        int         base_off;
        int         base_cc;
        prog = $random(seed);
        if (prog == exp_program) prog = prog ^ 7'd1;
        base_on = on_count;
        base_off = off_count;
        base_cc = cc_count;
        send_byte({4'h9, CHAN});
        send_byte({1'b0, 7'd60});
        send_byte({4'hC, CHAN});
        send_byte({1'b0, prog});
        wait_for_program("test_status_abort", prog);
        exp_program = prog;
        settle();
        check_value("test_status_abort", "note_on pulses", base_on, on_count);
        check_value("test_status_abort", "note_off pulses", base_off, off_count);
        check_value("test_status_abort", "program", exp_program, program_num);
        send_byte({1'b0, 7'($random(seed))});
        settle();
        check_value("test_status_abort", "note_on pulses", base_on, on_count);
        check_value("test_status_abort", "note_off pulses", base_off, off_count);
        check_value("test_status_abort", "cc_valid pulses", base_cc, cc_count);
        check_value("test_status_abort", "program", exp_program, program_num);
        check_tracker("test_status_abort");
    endtask

    initial begin
        seed = 15305;
        errors = 0;
        checks = 0;
        on_count = 0;
        off_count = 0;
        cc_count = 0;
        held_model = '0;
        exp_count = 0;
        exp_program = 7'd0;
        reset = 1'b1;
        rx = 1'b1;
        channel = CHAN;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_tracker("reset");
        check_value("reset", "program", exp_program, program_num);
        test_note_on_off();
        test_velocity_zero();
        test_channel_filter();
        test_program_cc();
        test_held_set();
        test_status_abort();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+rtl
rtl/midi_pkg.sv
rtl/midi_uart_rx.sv
rtl/midi_parser.sv
rtl/midi_note_tracker.sv
rtl/midi_top.sv
testbench/tb_midi_top.sv

//--- Bender.yml
package:
  name: midi_rx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/midi_pkg.sv
      - rtl/midi_uart_rx.sv
      - rtl/midi_parser.sv
      - rtl/midi_note_tracker.sv
      - rtl/midi_top.sv
  - target: simulation
    files:
      - testbench/tb_midi_top.sv
